//--- files.f
hw/softmc_pkg.sv
hw/dfi_cmd_if.sv
hw/instr_queue.sv
hw/seq_engine.sv
hw/cmd_issue.sv
hw/rdback_fifo.sv
hw/softmc_top.sv
test/softmc_tb.sv

//--- hw/cmd_issue.sv
module cmd_issue
	import softmc_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	dfi_cmd_if.issue               cmd,
	output logic [ROW_WIDTH-1:0]   dfi_address,
	output logic [BANK_WIDTH-1:0]  dfi_bank,
	output logic                   dfi_cs_n,
	output logic                   dfi_ras_n,
	output logic                   dfi_cas_n,
	output logic                   dfi_we_n,
	output logic                   dfi_wrdata_en,
	output logic [BURST_WIDTH-1:0] dfi_wrdata,
	output logic                   dfi_rddata_en
);

	logic                     ras_d;
	logic                     cas_d;
	logic                     we_d;
	logic                     pin_write;
	logic [WR_BYTE_WIDTH-1:0] wr_byte_q;
	logic [N_CWL-1:0]         wr_sr;
	logic [WR_BYTE_WIDTH-1:0] byte_sr [N_CWL];

	// ddr3 truth table, all active low
	always_comb begin
		ras_d = 1'b1;
		cas_d = 1'b1;
		we_d  = 1'b1;
		if (cmd.valid) begin
			case (cmd.op)
				op_act: ras_d = 1'b0;
				op_pre: begin
					ras_d = 1'b0;
					we_d  = 1'b0;
				end
				op_wr: begin
					cas_d = 1'b0;
					we_d  = 1'b0;
				end
				op_rd:  cas_d = 1'b0;
				op_ref: begin
					ras_d = 1'b0;
					cas_d = 1'b0;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dfi_cs_n      <= 1'b1;
			dfi_ras_n     <= 1'b1;
			dfi_cas_n     <= 1'b1;
			dfi_we_n      <= 1'b1;
			dfi_rddata_en <= 1'b0;
			wr_sr         <= '0;
		end else begin
			dfi_cs_n      <= !cmd.valid;
			dfi_ras_n     <= ras_d;
			dfi_cas_n     <= cas_d;
			dfi_we_n      <= we_d;
			dfi_rddata_en <= cmd.valid && cmd.op == op_rd; // same cycle as the read pins
			wr_sr         <= {wr_sr[N_CWL-2:0], pin_write};
		end
	end

	// address, bank and byte follow the last command
	always_ff @(posedge clk) begin
		if (cmd.valid) begin
			dfi_address <= cmd.addr;
			dfi_bank    <= cmd.bank;
			wr_byte_q   <= cmd.wr_byte;
		end
	end

	always_ff @(posedge clk) begin
		byte_sr[0] <= wr_byte_q;
		for (int i = 1; i < N_CWL; i++)
			byte_sr[i] <= byte_sr[i-1];
	end

	// write command currently on the pins
	assign pin_write = !dfi_cs_n && dfi_ras_n && !dfi_cas_n && !dfi_we_n;

	assign dfi_wrdata_en = wr_sr[N_CWL-1];
	assign dfi_wrdata    = {(BURST_WIDTH / WR_BYTE_WIDTH){byte_sr[N_CWL-1]}};

	// write data trails the write pulse by the pin register plus cwl
	a_wr_latency: assert property (@(posedge clk) disable iff (!rst_n)
		dfi_wrdata_en |-> $past(cmd.valid && cmd.op == op_wr, N_CWL + 1) &&
			dfi_wrdata[WR_BYTE_WIDTH-1:0] == $past(cmd.wr_byte, N_CWL + 1));

endmodule

//--- hw/dfi_cmd_if.sv
// one decoded command per valid pulse, no back-pressure
interface dfi_cmd_if
	import softmc_pkg::*;
();

	logic                     valid;
	opcode_t                  op;
	logic [BANK_WIDTH-1:0]    bank;
	logic [ROW_WIDTH-1:0]     addr;
	logic [WR_BYTE_WIDTH-1:0] wr_byte; // only meaningful for op_wr

	modport engine (
		output valid,
		output op,
		output bank,
		output addr,
		output wr_byte
	);

	modport issue (
		input valid,
		input op,
		input bank,
		input addr,
		input wr_byte
	);

endinterface

//--- hw/instr_queue.sv
module instr_queue
	import softmc_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   app_en,
	input  logic [INSTR_WIDTH-1:0] app_instr,
	input  logic                   pop,
	input  logic                   seq_done,
	output logic                   app_ack,
	output logic                   iq_full,
	output logic [INSTR_WIDTH-1:0] instr,
	output logic                   empty,
	output logic                   seq_go
);

	logic [INSTR_WIDTH-1:0]  mem [IQ_DEPTH];
	logic [IQ_PTR_WIDTH-1:0] wr_ptr;
	logic [IQ_PTR_WIDTH-1:0] rd_ptr;
	logic [IQ_PTR_WIDTH:0]   count;
	logic [IQ_PTR_WIDTH:0]   count_next;
	logic                    push;
	logic                    start;

	assign iq_full = (count == IQ_DEPTH);
	assign empty   = (count == 0);
	assign app_ack = app_en && !iq_full;
	assign push    = app_ack;
	assign instr   = mem[rd_ptr]; // head, valid while !empty

	always_comb begin
		case ({push, pop})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	// an END accepted, or the last free slot taken
	assign start = (push && opcode_t'(app_instr[OP_MSB:OP_LSB]) == op_end) ||
		(count_next == IQ_DEPTH && !iq_full);

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= app_instr;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			seq_go <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			// a new start wins over the done of the previous run
			if (start)
				seq_go <= 1'b1;
			else if (seq_done)
				seq_go <= 1'b0;
		end
	end

	// a full queue has its write pointer on the unread head
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		iq_full |-> wr_ptr == rd_ptr);

endmodule

//--- hw/rdback_fifo.sv
module rdback_fifo
	import softmc_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [BURST_WIDTH-1:0] dfi_rddata,
	input  logic                   dfi_rddata_valid,
	input  logic                   rdback_fifo_rden,
	output logic                   rdback_fifo_empty,
	output logic [BURST_WIDTH-1:0] rdback_data
);

	logic [BURST_WIDTH-1:0]      mem [RDBACK_DEPTH];
	logic [RDBACK_PTR_WIDTH-1:0] wr_ptr;
	logic [RDBACK_PTR_WIDTH-1:0] rd_ptr;
	logic [RDBACK_PTR_WIDTH:0]   count;
	logic                        full;
	logic                        push;
	logic                        pop;

	assign full              = (count == RDBACK_DEPTH);
	assign rdback_fifo_empty = (count == 0);
	assign push              = dfi_rddata_valid && !full; // overflow words are lost
	assign pop               = rdback_fifo_rden && !rdback_fifo_empty;
	assign rdback_data       = mem[rd_ptr]; // fall-through head

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= dfi_rddata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// memory returned a burst the host had no room for
	a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
		dfi_rddata_valid |-> !full);

endmodule

//--- hw/seq_engine.sv
module seq_engine
	import softmc_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   seq_go,
	input  logic                   dfi_init_complete,
	input  logic [INSTR_WIDTH-1:0] instr,
	input  logic                   empty,
	output logic                   pop,
	output logic                   seq_done,
	output logic                   processing_iseq,
	dfi_cmd_if.engine              cmd
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_wait
	} state_t;

	state_t                 state;
	opcode_t                op;
	logic [ROW_WIDTH-1:0]   wait_cnt;
	logic [ROW_WIDTH-1:0]   field_addr;
	logic                   is_cmd;
	logic                   running;

	assign op         = opcode_t'(instr[OP_MSB:OP_LSB]);
	assign field_addr = instr[ADDR_MSB:ADDR_LSB];
	assign running    = (state == st_run);

	always_comb begin
		case (op)
			op_act, op_pre, op_wr, op_rd, op_ref: is_cmd = 1'b1;
			default:                              is_cmd = 1'b0;
		endcase
	end

	// one pop per run cycle, END included
	assign pop      = running && !empty;
	assign seq_done = running && (empty || op == op_end);

	assign processing_iseq = (state != st_idle);

	// command fields straight from the head instruction
	assign cmd.valid   = running && !empty && is_cmd;
	assign cmd.op      = op;
	assign cmd.bank    = instr[BANK_MSB:BANK_LSB];
	assign cmd.addr    = field_addr;
	assign cmd.wr_byte = instr[WRB_MSB:WRB_LSB];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= st_idle;
			wait_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (seq_go && dfi_init_complete)
						state <= st_run;
				end
				st_run: begin
					if (seq_done) begin
						state <= st_idle;
					end else if (op == op_wait && field_addr != '0) begin
						// n idle cycles before the next pop
						state    <= st_wait;
						wait_cnt <= field_addr - 1'b1;
					end
				end
				st_wait: begin
					if (wait_cnt == '0)
						state <= st_run;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// the head must hold a real instruction when taken
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !$isunknown(instr));

endmodule

//--- hw/softmc_pkg.sv
package softmc_pkg;

	// dram side widths
	localparam int ROW_WIDTH   = 16;
	localparam int BANK_WIDTH  = 3;
	localparam int DQ_WIDTH    = 64;
	localparam int BURST_WIDTH = 4 * DQ_WIDTH; // four beats per controller clock

	// host side
	localparam int INSTR_WIDTH   = 32;
	localparam int WR_BYTE_WIDTH = 8;

	// queue depths, both powers of two
	localparam int IQ_DEPTH         = 16;
	localparam int IQ_PTR_WIDTH     = $clog2(IQ_DEPTH);
	localparam int RDBACK_DEPTH     = 8;
	localparam int RDBACK_PTR_WIDTH = $clog2(RDBACK_DEPTH);

	// latencies in controller clocks
	localparam int N_CWL = 5;
	localparam int N_CL  = 5;  // memory model only

	// instruction layout
	localparam int OP_MSB   = 31;
	localparam int OP_LSB   = 28;
	localparam int BANK_MSB = 26;
	localparam int BANK_LSB = 24;
	localparam int WRB_MSB  = 23;
	localparam int WRB_LSB  = 16;
	localparam int ADDR_MSB = 15; // also the wait count
	localparam int ADDR_LSB = 0;

	// opcode lives in the top nibble of every instruction
	typedef enum logic [3:0] {
		op_act  = 4'h1,
		op_pre  = 4'h2,
		op_wr   = 4'h3,
		op_rd   = 4'h4,
		op_ref  = 4'h5,
		op_wait = 4'h6,
		op_end  = 4'hf
	} opcode_t;

endpackage

//--- hw/softmc_top.sv
module softmc_top
	import softmc_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   app_en,
	input  logic [INSTR_WIDTH-1:0] app_instr,
	input  logic                   dfi_init_complete,
	input  logic [BURST_WIDTH-1:0] dfi_rddata,
	input  logic                   dfi_rddata_valid,
	input  logic                   rdback_fifo_rden,
	output logic                   app_ack,
	output logic                   iq_full,
	output logic                   processing_iseq,
	output logic [ROW_WIDTH-1:0]   dfi_address,
	output logic [BANK_WIDTH-1:0]  dfi_bank,
	output logic                   dfi_cs_n,
	output logic                   dfi_ras_n,
	output logic                   dfi_cas_n,
	output logic                   dfi_we_n,
	output logic                   dfi_wrdata_en,
	output logic [BURST_WIDTH-1:0] dfi_wrdata,
	output logic                   dfi_rddata_en,
	output logic                   rdback_fifo_empty,
	output logic [BURST_WIDTH-1:0] rdback_data
);

	logic                   pop;
	logic                   empty;
	logic                   seq_go;
	logic                   seq_done;
	logic [INSTR_WIDTH-1:0] instr;

	dfi_cmd_if cmd_bus ();

	instr_queue instr_queue_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.app_en    (app_en),
		.app_instr (app_instr),
		.pop       (pop),
		.seq_done  (seq_done),
		.app_ack   (app_ack),
		.iq_full   (iq_full),
		.instr     (instr),
		.empty     (empty),
		.seq_go    (seq_go)
	);

	seq_engine seq_engine_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.seq_go            (seq_go),
		.dfi_init_complete (dfi_init_complete), // hold off until phy is ready
		.instr             (instr),
		.empty             (empty),
		.pop               (pop),
		.seq_done          (seq_done),
		.processing_iseq   (processing_iseq),
		.cmd               (cmd_bus)
	);

	cmd_issue cmd_issue_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd           (cmd_bus),
		.dfi_address   (dfi_address),
		.dfi_bank      (dfi_bank),
		.dfi_cs_n      (dfi_cs_n),
		.dfi_ras_n     (dfi_ras_n),
		.dfi_cas_n     (dfi_cas_n),
		.dfi_we_n      (dfi_we_n),
		.dfi_wrdata_en (dfi_wrdata_en),
		.dfi_wrdata    (dfi_wrdata),
		.dfi_rddata_en (dfi_rddata_en)
	);

	rdback_fifo rdback_fifo_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.dfi_rddata        (dfi_rddata),
		.dfi_rddata_valid  (dfi_rddata_valid),
		.rdback_fifo_rden  (rdback_fifo_rden),
		.rdback_fifo_empty (rdback_fifo_empty),
		.rdback_data       (rdback_data)
	);

endmodule

//--- test/softmc_stim.txt
# tag instruction(hex) [read word(hex)]
# seq and rd form the main sequence, fill lines load the queue-full test
seq  12000010
seq  60000003
seq  32a50040
rd   42000040 0123456789abcdef
seq  60000002
seq  313c0008
rd   41000008 fedcba9876543210
rd   42000048 5a5a0000ffff1234
seq  22000400
seq  50000000
seq  f0000000
fill 50000000
fill 10000001
fill 21000000
fill 50000000
fill 12000002
fill 22000000
fill 13000003
fill 23000000
fill 50000000
fill 14000004
fill 24000000
fill 15007fff
fill 25000000
fill 50000000
fill 1600abcd
fill 26000000

//--- test/softmc_tb.sv
module softmc_tb
	import softmc_pkg::*;
();

	logic                   clk;
	logic                   rst_n;
	logic                   app_en;
	logic [INSTR_WIDTH-1:0] app_instr;
	logic                   dfi_init_complete;
	logic [BURST_WIDTH-1:0] dfi_rddata;
	logic                   dfi_rddata_valid;
	logic                   rdback_fifo_rden;
	logic                   app_ack;
	logic                   iq_full;
	logic                   processing_iseq;
	logic [ROW_WIDTH-1:0]   dfi_address;
	logic [BANK_WIDTH-1:0]  dfi_bank;
	logic                   dfi_cs_n;
	logic                   dfi_ras_n;
	logic                   dfi_cas_n;
	logic                   dfi_we_n;
	logic                   dfi_wrdata_en;
	logic [BURST_WIDTH-1:0] dfi_wrdata;
	logic                   dfi_rddata_en;
	logic                   rdback_fifo_empty;
	logic [BURST_WIDTH-1:0] rdback_data;

	logic [31:0] stream_q [$]; // main sequence, END included
	logic [31:0] fill_q [$];
	logic [63:0] rd_word_q [$];
	int          due_q [$];    // cycles at which the memory answers
	int          cmd_cyc_q [$];
	logic [21:0] cmd_pins_q [$]; // {ras, cas, we, bank, addr}
	int          wr_cyc_q [$];
	logic [BURST_WIDTH-1:0] wr_data_q [$];
	int cyc;
	int rd_idx;
	int checks;
	int errors;
	int test_err;

	softmc_top softmc_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// pin monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n && !dfi_cs_n) begin
			cmd_cyc_q.push_back(cyc);
			cmd_pins_q.push_back({dfi_ras_n, dfi_cas_n, dfi_we_n, dfi_bank, dfi_address});
		end
		if (rst_n && dfi_wrdata_en) begin
			wr_cyc_q.push_back(cyc);
			wr_data_q.push_back(dfi_wrdata);
		end
		if (rst_n && dfi_rddata_en)
			due_q.push_back(cyc + N_CL);
	end

	// memory responder
	always @(posedge clk) begin
		#1;
		dfi_rddata_valid = 1'b0;
		if (due_q.size() > 0 && due_q[0] == cyc) begin
			void'(due_q.pop_front());
			dfi_rddata_valid = 1'b1;
			dfi_rddata = (rd_idx < rd_word_q.size()) ? {4{rd_word_q[rd_idx]}} : '0;
			rd_idx++;
		end
	end

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("Fail at %0t: %s", $time, msg);
			errors++;
			test_err++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic test_done(input string name);
		$display("test %s: %s", name, (test_err == 0) ? "ok" : "errors seen");
		test_err = 0;
	endtask

	task automatic load_stim();
		int fd;
		string line;
		string tag;
		logic [31:0] w;
		logic [63:0] d;
		fd = $fopen("test/softmc_stim.txt", "r");
		if (fd == 0)
			abort_run("cannot open the stimulus file test/softmc_stim.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 3 || line[0] == "#")
				continue;
			void'($sscanf(line, "%s %h %h", tag, w, d));
			if (tag == "fill") begin
				fill_q.push_back(w);
			end else begin
				stream_q.push_back(w);
				if (tag == "rd")
					rd_word_q.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// called at 1 unit after an edge, returns likewise
	task automatic push_instr(input logic [31:0] w);
		int t;
		logic got;
		t = 0;
		got = 1'b0;
		app_instr = w;
		app_en = 1'b1;
		while (!got) begin
			#4 got = app_ack;
			@(posedge clk);
			#1;
			if (++t > 100)
				abort_run("timeout while waiting for app_ack");
		end
		app_en = 1'b0;
	endtask

	task automatic wait_busy(input logic val);
		int t;
		t = 0;
		while (processing_iseq !== val) begin
			@(posedge clk);
			#1;
			if (++t > 500)
				abort_run("timeout while waiting for processing_iseq to change");
		end
	endtask

	// expected {ras_n, cas_n, we_n} from the ddr3 truth table
	function automatic logic [2:0] encode(input logic [3:0] op);
		case (op)
			4'h1:    return 3'b011;
			4'h2:    return 3'b010;
			4'h3:    return 3'b100;
			4'h4:    return 3'b101;
			4'h5:    return 3'b001;
			default: return 3'b111;
		endcase
	endfunction

	initial begin
		int k;
		int wait_sum;
		int t;
		logic [31:0] w;
		logic [21:0] exp_pins;
		cyc = 0;
		rd_idx = 0;
		checks = 0;
		errors = 0;
		test_err = 0;
		rst_n = 1'b0;
		app_en = 1'b0;
		app_instr = '0;
		dfi_init_complete = 1'b1;
		dfi_rddata = '0;
		dfi_rddata_valid = 1'b0;
		rdback_fifo_rden = 1'b0;
		load_stim();
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;

		check(!app_ack && !processing_iseq && !dfi_wrdata_en && !dfi_rddata_en, "enables low");
		check(dfi_cs_n && dfi_ras_n && dfi_cas_n && dfi_we_n, "control pins idle high");
		check(!iq_full && rdback_fifo_empty, "queue and fifo flags");
		test_done("reset");

		foreach (stream_q[i])
			push_instr(stream_q[i]);
		wait_busy(1'b1);
		wait_busy(1'b0); // falls after END
		t = 0;
		while (due_q.size() > 0 || t < N_CWL + 2) begin
			@(posedge clk);
			#1;
			if (++t > 200)
				abort_run("timeout while waiting for outstanding reads");
		end
		k = 0;
		wait_sum = 0;
		foreach (stream_q[i]) begin
			w = stream_q[i];
			if (w[31:28] == 4'h6) begin
				wait_sum += w[15:0];
			end else if (w[31:28] != 4'hf) begin
				exp_pins = {encode(w[31:28]), w[26:24], w[15:0]};
				check(k < cmd_pins_q.size(), "command missing on the pins");
				check(cmd_pins_q[k] === exp_pins, $sformatf("command %0d pins %h, expected %h",
					k, cmd_pins_q[k], exp_pins));
				if (k > 0)
					check(cmd_cyc_q[k] - cmd_cyc_q[k-1] >= wait_sum + 1,
						$sformatf("command %0d too early after wait %0d", k, wait_sum));
				wait_sum = 0;
				k++;
			end
		end
		check(cmd_pins_q.size() == k, "extra commands on the pins");
		test_done("command stream and waits");

		k = 0;
		foreach (stream_q[i]) begin
			if (stream_q[i][31:28] == 4'h3) begin
				check(k < wr_cyc_q.size(), "write data missing");
				check(wr_cyc_q[k] == cmd_cyc_q[i - non_cmd_count(i)] + N_CWL,
					"write data latency");
				check(wr_data_q[k] === {32{stream_q[i][23:16]}}, "write data value");
				k++;
			end
		end
		check(wr_cyc_q.size() == k, "extra write data cycles");
		test_done("write latency");

		foreach (rd_word_q[i]) begin
			check(!rdback_fifo_empty, "readback fifo empty too early");
			check(rdback_data === {4{rd_word_q[i]}}, $sformatf("readback word %0d", i));
			rdback_fifo_rden = 1'b1;
			@(posedge clk);
			#1 rdback_fifo_rden = 1'b0;
		end
		check(rdback_fifo_empty, "readback fifo not empty after drain");
		test_done("readback");

		dfi_init_complete = 1'b0;
		k = cmd_pins_q.size();
		foreach (fill_q[i])
			push_instr(fill_q[i]);
		check(iq_full, "iq_full after filling");
		app_instr = fill_q[0];
		app_en = 1'b1;
		repeat (3) begin
			#4 check(!app_ack, "app_ack while full");
			@(posedge clk);
			#1;
		end
		app_en = 1'b0;
		dfi_init_complete = 1'b1;
		wait_busy(1'b1);
		wait_busy(1'b0);
		check(!iq_full, "queue still full after run");
		check(cmd_pins_q.size() - k == fill_q.size(), "not every queued command issued");
		test_done("queue full");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// non-command entries before index i, to map it onto the pin log
	function automatic int non_cmd_count(input int i);
		int n;
		n = 0;
		for (int j = 0; j < i; j++)
			if (stream_q[j][31:28] == 4'h6 || stream_q[j][31:28] == 4'hf)
				n++;
		return n;
	endfunction

endmodule
